// File: flist.f
src/battleship_pkg.sv
src/fleet_board.sv
src/game_fsm.sv
src/display_driver.sv
src/battleship_top.sv
testbench/clock_gen.sv
testbench/tb_battleship.sv

// File: src/battleship_pkg.sv
`default_nettype none

package battleship_pkg;

  // Board square, X in the upper bits and Y in the lower bits
  typedef logic [3:0] coord_t;

  localparam int FLEET_SIZE = 4;              // Ships per player

  typedef logic [2:0] count_t;                // Placed or sunk ships, 0 to FLEET_SIZE

  localparam coord_t EMPTY_SQUARE = 4'b1111;  // Marker only, slots are qualified by count

  // Screen hold times in clock cycles
  localparam int ERROR_HOLD    = 50;
  localparam int SCORE_HOLD    = 50;
  localparam int WIN_SWEEP_LEN = 14;          // Last step of the winner animation

  typedef enum logic [3:0] {
    IDLE        = 4'd0,
    PLACE_A     = 4'd1,
    PLACE_B     = 4'd2,
    ERROR_A     = 4'd3,
    ERROR_B     = 4'd4,
    SCORE       = 4'd5,
    SHOOT_A     = 4'd6,
    SHOOT_B     = 4'd7,
    SCORE_FIRST = 4'd8,
    WINNER      = 4'd9
  } game_state_t;

  // Active-high segments, gfedcba in bits 6:0
  typedef logic [7:0] seg_t;

  localparam seg_t SEG_0    = 8'b0011_1111;
  localparam seg_t SEG_1    = 8'b0000_0110;
  localparam seg_t SEG_2    = 8'b0101_1011;
  localparam seg_t SEG_3    = 8'b0100_1111;
  localparam seg_t SEG_4    = 8'b0110_0110;

  localparam seg_t SEG_I    = 8'b0000_0110;
  localparam seg_t SEG_D    = 8'b0101_1110;   // Lower case d
  localparam seg_t SEG_L    = 8'b0011_1000;
  localparam seg_t SEG_E    = 8'b0111_1001;
  localparam seg_t SEG_A    = 8'b0111_0111;
  localparam seg_t SEG_B    = 8'b0111_1100;   // Lower case b
  localparam seg_t SEG_R    = 8'b0101_0000;   // Lower case r
  localparam seg_t SEG_O    = 8'b0101_1100;   // Lower case o
  localparam seg_t SEG_DASH = 8'b0100_0000;
  localparam seg_t SEG_OFF  = 8'b0000_0000;

  // LED patterns
  localparam logic [7:0] LED_IDLE = 8'b1001_1001;  // LEDs 7, 4, 3 and 0
  localparam logic [7:0] LED_ALL  = 8'b1111_1111;

endpackage

`default_nettype wire

// File: src/battleship_top.sv
`timescale 1ns/10ps
`default_nettype none

module battleship_top import battleship_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       pa_btn,
  input  logic       pb_btn,
  input  logic [1:0] x,
  input  logic [1:0] y,
  output seg_t       disp0,
  output seg_t       disp1,
  output seg_t       disp2,
  output seg_t       disp3,
  output logic [7:0] led
);

  coord_t      square;
  logic        place_a;
  logic        place_b;
  logic        fire_a;
  logic        fire_b;
  logic        occupied_a;
  logic        occupied_b;
  logic        hit_a;
  logic        hit_b;
  logic        full_a;
  logic        full_b;
  logic        sunk_all_a;
  logic        sunk_all_b;
  count_t      placed_a;
  count_t      placed_b;
  count_t      sunk_a;         // Score of player B
  count_t      sunk_b;         // Score of player A
  game_state_t state;
  logic        hit_flag;
  logic [3:0]  sweep_step;

  assign square = {x, y};

  // Fleet A is fired at by player B
  fleet_board fleet_a (
    .clk          (clk),
    .rst          (rst),
    .place        (place_a),
    .fire         (fire_b),
    .square       (square),
    .occupied     (occupied_a),
    .hit          (hit_a),
    .fleet_full   (full_a),
    .all_sunk     (sunk_all_a),
    .placed_count (placed_a),
    .sunk_count   (sunk_a)
  );

  fleet_board fleet_b (
    .clk          (clk),
    .rst          (rst),
    .place        (place_b),
    .fire         (fire_a),
    .square       (square),
    .occupied     (occupied_b),
    .hit          (hit_b),
    .fleet_full   (full_b),
    .all_sunk     (sunk_all_b),
    .placed_count (placed_b),
    .sunk_count   (sunk_b)
  );

  game_fsm u_fsm (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .pa_btn     (pa_btn),
    .pb_btn     (pb_btn),
    .occupied_a (occupied_a),
    .occupied_b (occupied_b),
    .hit_a      (hit_a),
    .hit_b      (hit_b),
    .full_a     (full_a),
    .full_b     (full_b),
    .sunk_all_a (sunk_all_a),
    .sunk_all_b (sunk_all_b),
    .place_a    (place_a),
    .place_b    (place_b),
    .fire_a     (fire_a),
    .fire_b     (fire_b),
    .state      (state),
    .hit_flag   (hit_flag),
    .sweep_step (sweep_step)
  );

  display_driver u_disp (
    .state      (state),
    .square     (square),
    .count_a    (placed_a),
    .count_b    (placed_b),
    .score_a    (sunk_b),
    .score_b    (sunk_a),
    .hit_flag   (hit_flag),
    .sweep_step (sweep_step),
    .disp0      (disp0),
    .disp1      (disp1),
    .disp2      (disp2),
    .disp3      (disp3),
    .led        (led)
  );

endmodule

`default_nettype wire

// File: src/display_driver.sv
`timescale 1ns/10ps
`default_nettype none

module display_driver import battleship_pkg::*; (
  input  game_state_t state,
  input  coord_t      square,
  input  count_t      count_a,     // Ships placed by A
  input  count_t      count_b,     // Ships placed by B
  input  count_t      score_a,
  input  count_t      score_b,
  input  logic        hit_flag,
  input  logic [3:0]  sweep_step,
  output seg_t        disp0,
  output seg_t        disp1,
  output seg_t        disp2,
  output seg_t        disp3,       // Leftmost digit
  output logic [7:0]  led
);

  // Digits 0 to 4 cover both coordinates and scores
  function automatic seg_t digit_seg(input count_t value);
    case (value)
      3'd0:    return SEG_0;
      3'd1:    return SEG_1;
      3'd2:    return SEG_2;
      3'd3:    return SEG_3;
      3'd4:    return SEG_4;
      default: return SEG_DASH;
    endcase
  endfunction

  always_comb begin
    disp0 = SEG_OFF;
    disp1 = SEG_OFF;
    disp2 = SEG_OFF;
    disp3 = SEG_OFF;
    led   = 8'h00;

    case (state)
      IDLE: begin
        disp3 = SEG_I;
        disp2 = SEG_D;
        disp1 = SEG_L;
        disp0 = SEG_E;
        led   = LED_IDLE;
      end

      PLACE_A, PLACE_B, SHOOT_A, SHOOT_B: begin
        disp3 = (state == PLACE_A || state == SHOOT_A) ? SEG_A : SEG_B;
        disp1 = digit_seg(count_t'(square[3:2]));   // X
        disp0 = digit_seg(count_t'(square[1:0]));   // Y
        if (state == PLACE_A || state == SHOOT_A) begin
          led[7] = 1'b1;
        end else begin
          led[0] = 1'b1;
        end
        if (state == PLACE_A) begin
          led[5:4] = count_a[1:0];
        end else if (state == PLACE_B) begin
          led[3:2] = count_b[1:0];
        end else begin
          led[5:4] = score_a[1:0];                  // Running scores while shooting
          led[3:2] = score_b[1:0];
        end
      end

      ERROR_A, ERROR_B: begin
        disp3 = SEG_E;
        disp2 = SEG_R;
        disp1 = SEG_R;
        disp0 = SEG_O;
        led   = LED_IDLE;
      end

      SCORE_FIRST, SCORE, WINNER: begin
        disp2 = digit_seg(score_a);
        disp1 = SEG_DASH;
        disp0 = digit_seg(score_b);
        if (state == SCORE_FIRST) begin
          led = LED_IDLE;
        end else if (state == SCORE) begin
          led = hit_flag ? LED_ALL : 8'h00;         // Flash on a hit
        end else begin
          if (score_a == count_t'(FLEET_SIZE)) begin
            disp3 = SEG_A;
          end else if (score_b == count_t'(FLEET_SIZE)) begin
            disp3 = SEG_B;
          end
          // Pair of LEDs walks right, two cycles per position
          if (sweep_step < WIN_SWEEP_LEN) begin
            led = 8'b1100_0000 >> sweep_step[3:1];
          end
        end
      end

      default: led = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

// File: src/fleet_board.sv
`timescale 1ns/10ps
`default_nettype none

module fleet_board import battleship_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   place,         // Store square in the next free slot
  input  logic   fire,          // Opponent shot at square
  input  coord_t square,
  output logic   occupied,      // Square holds a placed ship
  output logic   hit,           // Square holds a placed, unsunk ship
  output logic   fleet_full,
  output logic   all_sunk,
  output count_t placed_count,
  output count_t sunk_count
);

  coord_t                ship [FLEET_SIZE];  // Ship squares in placement order
  logic [FLEET_SIZE-1:0] sunk;
  logic [FLEET_SIZE-1:0] match;              // Placed ships on the current square

  // A slot only counts once it has been written
  always_comb begin
    for (int i = 0; i < FLEET_SIZE; i++) begin
      match[i] = (ship[i] == square) && (count_t'(i) < placed_count);
    end
  end

  assign occupied   = |match;
  assign hit        = |(match & ~sunk);
  assign fleet_full = (placed_count == count_t'(FLEET_SIZE));
  assign all_sunk   = (sunk_count == count_t'(FLEET_SIZE));

  always_comb begin
    sunk_count = '0;
    for (int i = 0; i < FLEET_SIZE; i++) begin
      sunk_count = sunk_count + count_t'(sunk[i]);  // Population count
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      placed_count <= '0;
      sunk         <= '0;
      for (int i = 0; i < FLEET_SIZE; i++) begin
        ship[i] <= EMPTY_SQUARE;
      end
    end else begin
      if (place) begin
        for (int i = 0; i < FLEET_SIZE; i++) begin
          if (placed_count == count_t'(i)) begin
            ship[i] <= square;                      // Next free slot
          end
        end
        placed_count <= placed_count + 1'b1;
      end
      if (fire) begin
        sunk <= sunk | match;                       // Every ship on the square goes down
      end
    end
  end

  // The FSM must stop placing once all four ships are down on the board
  a_no_place_when_full: assert property (
    @(posedge clk) disable iff (rst)
    place |-> !fleet_full
  ) else $error("place pulse with a full fleet");

  // Placement and shooting phases never overlap
  a_place_fire_exclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(place && fire)
  ) else $error("place and fire in the same cycle");

endmodule

`default_nettype wire

// File: src/game_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module game_fsm import battleship_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  logic        pa_btn,
  input  logic        pb_btn,
  input  logic        occupied_a,
  input  logic        occupied_b,
  input  logic        hit_a,        // Shot would hit a ship of player A
  input  logic        hit_b,        // Shot would hit a ship of player B
  input  logic        full_a,
  input  logic        full_b,
  input  logic        sunk_all_a,
  input  logic        sunk_all_b,
  output logic        place_a,
  output logic        place_b,
  output logic        fire_a,       // Player A shoots at fleet B
  output logic        fire_b,       // Player B shoots at fleet A
  output game_state_t state,
  output logic        hit_flag,     // Last shot was a hit
  output logic [3:0]  sweep_step    // Winner animation step
);

  logic                                         turn;      // Low when A shoots next
  // Shared by error and score holds
  logic [$clog2((ERROR_HOLD > SCORE_HOLD ? ERROR_HOLD : SCORE_HOLD) + 1)-1:0] hold_cnt;
  logic                                         overlap_a;
  logic                                         overlap_b;

  // Player B may not reuse any square already taken by either fleet
  assign overlap_a = occupied_a;
  assign overlap_b = occupied_a || occupied_b;

  assign place_a = (state == PLACE_A) && pa_btn && !overlap_a && !full_a;
  assign place_b = (state == PLACE_B) && pb_btn && !overlap_b && !full_b;
  assign fire_a  = (state == SHOOT_A) && pa_btn;
  assign fire_b  = (state == SHOOT_B) && pb_btn;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= IDLE;
      turn       <= 1'b0;
      hit_flag   <= 1'b0;
      hold_cnt   <= '0;
      sweep_step <= 4'd0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= PLACE_A;
          end
        end

        PLACE_A: begin
          if (full_a) begin
            state <= PLACE_B;                 // Fourth ship is down
          end else if (pa_btn && overlap_a) begin
            state <= ERROR_A;
          end
        end

        PLACE_B: begin
          if (full_b) begin
            state <= SCORE_FIRST;
          end else if (pb_btn && overlap_b) begin
            state <= ERROR_B;
          end
        end

        ERROR_A, ERROR_B: begin
          if (hold_cnt < ERROR_HOLD) begin
            hold_cnt <= hold_cnt + 1'b1;
          end else begin
            hold_cnt <= '0;
            state    <= (state == ERROR_A) ? PLACE_A : PLACE_B;  // Same player retries
          end
        end

        SCORE_FIRST: begin
          if (hold_cnt < SCORE_HOLD) begin
            hold_cnt <= hold_cnt + 1'b1;
          end else begin
            hold_cnt <= '0;
            state    <= SHOOT_A;
          end
        end

        SCORE: begin
          if (sunk_all_a || sunk_all_b) begin
            state <= WINNER;                  // Game over skips the hold
          end else if (hold_cnt < SCORE_HOLD) begin
            hold_cnt <= hold_cnt + 1'b1;
          end else begin
            hold_cnt <= '0;
            state    <= turn ? SHOOT_B : SHOOT_A;
          end
        end

        SHOOT_A: begin
          if (fire_a) begin
            hit_flag <= hit_b;
            turn     <= ~turn;
            state    <= SCORE;
          end
        end

        SHOOT_B: begin
          if (fire_b) begin
            hit_flag <= hit_a;
            turn     <= ~turn;
            state    <= SCORE;
          end
        end

        WINNER: begin
          // Only reset leaves this state
          if (sweep_step == WIN_SWEEP_LEN) begin
            sweep_step <= 4'd0;
          end else begin
            sweep_step <= sweep_step + 1'b1;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  a_state_legal: assert property (
    @(posedge clk) disable iff (rst)
    state inside {IDLE, PLACE_A, PLACE_B, ERROR_A, ERROR_B,
                  SCORE, SHOOT_A, SHOOT_B, SCORE_FIRST, WINNER}
  ) else $error("illegal game state %0d", state);

endmodule

`default_nettype wire

// File: testbench/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);  // Eight cycles of reset
    #2;
    rst = 1'b0;                 // Released with the stimulus timing
  end

endmodule

`default_nettype wire

// File: testbench/tb_battleship.sv
`timescale 1ns/10ps
`default_nettype none

module tb_battleship import battleship_pkg::*; ();

  localparam logic [31:0] SEED = 32'h3fd63f0a;

  logic       clk;
  logic       rst;
  logic       start;
  logic       pa_btn;
  logic       pb_btn;
  logic [1:0] x;
  logic [1:0] y;
  seg_t       disp0;
  seg_t       disp1;
  seg_t       disp2;
  seg_t       disp3;
  logic [7:0] led;

  // Model of the game
  game_state_t exp_state;
  logic [2:0]  cnt_a;
  logic [2:0]  cnt_b;
  logic [2:0]  score_a;
  logic [2:0]  score_b;
  logic        exp_hit;
  int          sweep;
  logic        check_en;
  logic [3:0]  ships_a [FLEET_SIZE];
  logic [3:0]  ships_b [FLEET_SIZE];
  logic [3:0]  sunk_a;
  logic [3:0]  sunk_b;
  logic [3:0]  perm    [16];
  logic [3:0]  squares [16];
  logic [3:0]  shots_a [16];
  logic [3:0]  shots_b [16];
  logic [39:0] expd;

  clock_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  battleship_top dut (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .pa_btn (pa_btn),
    .pb_btn (pb_btn),
    .x      (x),
    .y      (y),
    .disp0  (disp0),
    .disp1  (disp1),
    .disp2  (disp2),
    .disp3  (disp3),
    .led    (led)
  );

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic seg_t digit_code(input int v);
    case (v)
      0:       return SEG_0;
      1:       return SEG_1;
      2:       return SEG_2;
      3:       return SEG_3;
      4:       return SEG_4;
      default: return SEG_DASH;
    endcase
  endfunction

  // Expected {disp3, disp2, disp1, disp0, led} for the model state
  function automatic logic [39:0] expected_display();
    seg_t       d3;
    seg_t       d2;
    seg_t       d1;
    seg_t       d0;
    logic [7:0] l;
    logic       side_a;
    d3 = SEG_OFF;
    d2 = SEG_OFF;
    d1 = SEG_OFF;
    d0 = SEG_OFF;
    l  = 8'h00;
    side_a = (exp_state == PLACE_A) || (exp_state == SHOOT_A);
    case (exp_state)
      IDLE: begin
        d3 = SEG_I;
        d2 = SEG_D;
        d1 = SEG_L;
        d0 = SEG_E;
        l  = LED_IDLE;
      end
      PLACE_A, PLACE_B, SHOOT_A, SHOOT_B: begin
        d3   = side_a ? SEG_A : SEG_B;
        d1   = digit_code(x);
        d0   = digit_code(y);
        l[7] = side_a;
        l[0] = !side_a;
        if (exp_state == PLACE_A) begin
          l[5:4] = cnt_a[1:0];
        end else if (exp_state == PLACE_B) begin
          l[3:2] = cnt_b[1:0];
        end else begin
          l[5:4] = score_a[1:0];  // Scores while shooting
          l[3:2] = score_b[1:0];
        end
      end
      ERROR_A, ERROR_B: begin
        d3 = SEG_E;
        d2 = SEG_R;
        d1 = SEG_R;
        d0 = SEG_O;
        l  = LED_IDLE;
      end
      default: begin
        d2 = digit_code(score_a);
        d1 = SEG_DASH;
        d0 = digit_code(score_b);
        if (exp_state == SCORE_FIRST) begin
          l = LED_IDLE;
        end else if (exp_state == SCORE) begin
          l = exp_hit ? LED_ALL : 8'h00;
        end else begin
          d3 = (score_a == FLEET_SIZE) ? SEG_A : SEG_B;
          if (sweep < WIN_SWEEP_LEN) begin
            l = 8'hc0 >> (sweep / 2);  // Two LEDs, two cycles per position
          end
        end
      end
    endcase
    return {d3, d2, d1, d0, l};
  endfunction

  // Comparison at the falling edge, inputs and state are settled
  always @(negedge clk) begin
    if (check_en) begin
      expd = expected_display();
      check_value("disp3", disp3, expd[39:32]);
      check_value("disp2", disp2, expd[31:24]);
      check_value("disp1", disp1, expd[23:16]);
      check_value("disp0", disp0, expd[15:8]);
      check_value("led", led, expd[7:0]);
      if (exp_state == WINNER) begin
        sweep = (sweep == WIN_SWEEP_LEN) ? 0 : sweep + 1;
      end
    end
  end

  // Polls just after each rising edge until the screen shows d3 and d0
  task automatic wait_screen(input seg_t d3, input seg_t d0, input int limit, output int n);
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
      if (n > limit) begin
        $display("Timeout: screen did not change within %0d cycles at %0t ns", limit, $time);
        abort_run();
      end
    end while (disp3 !== d3 || disp0 !== d0);
  endtask

  // btn 0 is start, 1 is player A, 2 is player B
  task automatic press(input int btn, input logic [1:0] px, input logic [1:0] py);
    @(posedge clk);
    #2;
    x      = px;
    y      = py;
    start  = (btn == 0);
    pa_btn = (btn == 1);
    pb_btn = (btn == 2);
    @(posedge clk);              // Sampling edge
    #2;
    start  = 1'b0;
    pa_btn = 1'b0;
    pb_btn = 1'b0;
  endtask

  task automatic make_perm();
    int         i;
    int         j;
    logic [3:0] t;
    for (i = 0; i < 16; i++) begin
      perm[i] = 4'(i);
    end
    for (i = 15; i > 0; i--) begin
      j       = $urandom % (i + 1);
      t       = perm[i];
      perm[i] = perm[j];
      perm[j] = t;
    end
  endtask

  task automatic place_ship(input int player, input logic [3:0] sq);
    int n;
    press(player, sq[3:2], sq[1:0]);
    if (player == 1) begin
      ships_a[cnt_a] = sq;
      cnt_a          = cnt_a + 1;
    end else begin
      ships_b[cnt_b] = sq;
      cnt_b          = cnt_b + 1;
    end
    if (player == 1 && cnt_a == FLEET_SIZE) begin
      wait_screen(SEG_B, digit_code(y), 5, n);
      check_value("cycles to player b", n, 1);
      exp_state = PLACE_B;
    end else if (player == 2 && cnt_b == FLEET_SIZE) begin
      wait_screen(SEG_OFF, SEG_0, 5, n);
      check_value("cycles to score screen", n, 1);
      exp_state = SCORE_FIRST;
      wait_screen(SEG_A, digit_code(y), SCORE_HOLD + 5, n);
      check_value("first score hold", n, SCORE_HOLD + 1);
      exp_state = SHOOT_A;
    end
  endtask

  task automatic try_overlap(input int player, input logic [3:0] sq);
    int n;
    press(player, sq[3:2], sq[1:0]);
    exp_state = (player == 1) ? ERROR_A : ERROR_B;
    wait_screen((player == 1) ? SEG_A : SEG_B, digit_code(y), ERROR_HOLD + 5, n);
    check_value("error hold", n, ERROR_HOLD + 1);
    exp_state = (player == 1) ? PLACE_A : PLACE_B;  // Same player, count unchanged
  endtask

  task automatic shoot(input logic [3:0] sq);
    int   n;
    int   i;
    logic by_b;
    by_b = (exp_state == SHOOT_B);
    press(by_b ? 2 : 1, sq[3:2], sq[1:0]);
    exp_hit = 1'b0;
    for (i = 0; i < FLEET_SIZE; i++) begin
      if (by_b && ships_a[i] == sq && !sunk_a[i]) begin
        sunk_a[i] = 1'b1;
        exp_hit   = 1'b1;
      end
      if (!by_b && ships_b[i] == sq && !sunk_b[i]) begin
        sunk_b[i] = 1'b1;
        exp_hit   = 1'b1;
      end
    end
    if (exp_hit && by_b) begin
      score_b = score_b + 1;
    end
    if (exp_hit && !by_b) begin
      score_a = score_a + 1;
    end
    exp_state = SCORE;
    if (score_a == FLEET_SIZE || score_b == FLEET_SIZE) begin
      wait_screen((score_a == FLEET_SIZE) ? SEG_A : SEG_B, digit_code(score_b), 5, n);
      check_value("cycles to winner", n, 1);
      sweep     = 0;
      exp_state = WINNER;
    end else begin
      wait_screen(by_b ? SEG_A : SEG_B, digit_code(y), SCORE_HOLD + 5, n);
      check_value("score hold", n, SCORE_HOLD + 1);
      exp_state = by_b ? SHOOT_A : SHOOT_B;     // Turns alternate
    end
  endtask

  initial begin
    int n;
    int k;
    int ia;
    int ib;
    void'($urandom(SEED));
    start     = 1'b0;
    pa_btn    = 1'b0;
    pb_btn    = 1'b0;
    x         = 2'd0;
    y         = 2'd0;
    exp_state = IDLE;
    cnt_a     = '0;
    cnt_b     = '0;
    score_a   = '0;
    score_b   = '0;
    exp_hit   = 1'b0;
    sunk_a    = '0;
    sunk_b    = '0;
    sweep     = 0;
    check_en  = 1'b0;
    make_perm();
    squares = perm;                         // A gets 0..3, B gets 4..7
    make_perm();
    shots_a = perm;
    make_perm();
    shots_b = perm;
    shots_b[0] = squares[0];                // Hit, then the same square again
    shots_b[1] = squares[0];

    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 20) begin
        $display("Timeout: reset was never released");
        abort_run();
      end
    end while (rst !== 1'b0);
    check_en = 1'b1;
    repeat (2) @(posedge clk);              // Idle screen

    press(0, 2'd0, 2'd0);
    exp_state = PLACE_A;

    place_ship(1, squares[0]);
    place_ship(1, squares[1]);
    try_overlap(1, squares[0]);
    place_ship(1, squares[2]);
    place_ship(1, squares[3]);

    place_ship(2, squares[4]);
    try_overlap(2, squares[1]);             // Square of player A
    try_overlap(2, squares[4]);             // Own square
    place_ship(2, squares[5]);
    place_ship(2, squares[6]);
    place_ship(2, squares[7]);

    ia = 0;
    ib = 0;
    for (k = 0; k < 40 && exp_state != WINNER; k++) begin
      if (exp_state == SHOOT_A) begin
        shoot(shots_a[ia % 16]);
        ia++;
      end else begin
        shoot(shots_b[ib % 16]);
        ib++;
      end
    end
    if (exp_state != WINNER) begin
      $display("No winner after %0d shots", k);
      abort_run();
    end

    repeat (2 * (WIN_SWEEP_LEN + 1) + 2) @(posedge clk);  // Two full sweeps
    @(negedge clk);
    #1;
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
